// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sprite_dma
FILELIST  ?= vlog.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: logic/obj_dma.sv
`timescale 1ns/1ns
`default_nettype none

module obj_dma import sprite_dma_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n,
    input  video_t                vid,
    input  wire                   busak_n,
    input  wire  [7:0]            dma_data,
    output logic                  busrq_n,
    output logic [tbl_addr_w-1:0] dma_addr,
    output logic                  dma_done,
    output obj_entry_t            entry
);

    logic [tbl_addr_w:0]  count;      // bit 10 marks the end of the copy.
    logic                 vb_l;       // vb one cen tick ago.
    logic                 h0_l;       // h bit 0 one cen tick ago.
    logic                 busak_l;    // grant one cen tick ago.
    logic                 vb_rise;
    logic                 h0_rise;
    logic                 advance;
    logic [obj_lanes-1:0] lane_we;
    logic [7:0]           lane_q [0:obj_lanes-2];
    logic [4:0]           lane3_q;    // the last lane only keeps five bits.
    logic [7:0]           idx_d;      // index delayed to match the RAM latency.
    logic                 valid_d;

    assign vb_rise = vid.vb & ~vb_l;
    assign h0_rise = vid.h[0] & ~h0_l;

    // free-run in display; while granted, one step per 4-tick slot at h = 2.
    // The first granted tick never steps, so entry 0 gets its own write slot.
    // Waiting for the grant holds the count at 0.
    assign advance = (busrq_n & busak_n) | ((vid.h == 2'd2) & ~busak_n & ~busak_l);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vb_l    <= 1'b0;
            h0_l    <= 1'b0;
            busak_l <= 1'b1;
            count   <= '0;
        end else if (vid.cen) begin
            vb_l    <= vid.vb;
            h0_l    <= vid.h[0];
            busak_l <= busak_n;
            if (vb_rise) begin
                count <= '0;
            end else if (advance) begin
                count[tbl_addr_w-1:0] <= count[tbl_addr_w-1:0] + 1'b1;
                // only a wrap during the copy sets the done bit, which then sticks.
                if (!busrq_n && (&count[tbl_addr_w-1:0])) count[tbl_addr_w] <= 1'b1;
            end
        end
    end

    // request the bus at the vb edge and give it back once the copy is over.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busrq_n <= 1'b1;
        end else if (vid.cen) begin
            if (vb_rise) busrq_n <= 1'b0;
            else if (count[tbl_addr_w]) busrq_n <= 1'b1;  // DMA done.
        end
    end

    assign dma_done = count[tbl_addr_w];
    assign dma_addr = scramble_addr(count);

    // a lane is written at h = 1, when the read data for the current count has arrived.
    always_comb begin
        for (int k = 0; k < obj_lanes; k++) begin
            lane_we[k] = ~busak_n & ~count[tbl_addr_w] & ~vid.h[1] & h0_rise
                       & (count[9:8] == k[1:0]);
        end
    end

    for (genvar k = 0; k < obj_lanes - 1; k++) begin : g_lane
        obj_ram #(.AW(8), .DW(8)) u_lane (
            .clk  (clk),
            .cen  (vid.cen),
            .we   (lane_we[k]),
            .addr (count[7:0]),
            .data (dma_data),
            .q    (lane_q[k])
        );
    end

    obj_ram #(.AW(8), .DW(5)) u_lane3 (
        .clk  (clk),
        .cen  (vid.cen),
        .we   (lane_we[obj_lanes-1]),
        .addr (count[7:0]),
        .data (dma_data[4:0]),   // upper table bits are not stored.
        .q    (lane3_q)
    );

    // entries are only offered once the copy is done and the bus is back.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d <= 1'b0;
        end else if (vid.cen) begin
            valid_d <= count[tbl_addr_w] & busak_n;
        end
    end

    always_ff @(posedge clk) begin
        if (vid.cen) idx_d <= count[7:0];
    end

    always_comb begin
        entry.idx        = idx_d;
        entry.attr.attr0 = lane_q[0];
        entry.attr.attr1 = lane_q[1];
        entry.attr.attr2 = lane_q[2];
        entry.attr.attr3 = lane3_q;
        entry.valid      = valid_d;
    end

endmodule

`default_nettype wire

// File: logic/obj_ram.sv
`timescale 1ns/1ns
`default_nettype none

module obj_ram #(
    parameter int AW = 8,
    parameter int DW = 8
) (
    input  wire           clk,
    input  wire           cen,
    input  wire           we,
    input  wire  [AW-1:0] addr,
    input  wire  [DW-1:0] data,
    output logic [DW-1:0] q
);

    logic [DW-1:0] mem [0:(1 << AW)-1];

    // write-first: a written word shows up on q in the same tick.
    always_ff @(posedge clk) begin
        if (cen) begin
            if (we) begin
                mem[addr] <= data;
                q         <= data;
            end else begin
                q <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/sprite_dma_pkg.sv
`default_nettype none

package sprite_dma_pkg;

    localparam int tbl_addr_w = 10;  // 1 KiB sprite table in work RAM.
    localparam int obj_lanes  = 4;   // three byte lanes and one 5-bit lane.

    // one sprite entry as the renderer sees it; lane 0 sits in the low bits.
    typedef struct packed {
        logic [4:0] attr3;
        logic [7:0] attr2;
        logic [7:0] attr1;
        logic [7:0] attr0;
    } obj_attr_t;

    typedef struct packed {
        logic [7:0] idx;    // object buffer address the entry was read from.
        obj_attr_t  attr;
        logic       valid;  // only set in display, once the table copy is done.
    } obj_entry_t;

    typedef struct packed {
        logic                  wr;    // single-cycle write strobe.
        logic [tbl_addr_w-1:0] addr;
        logic [7:0]            data;
    } cpu_wr_t;

    typedef struct packed {
        logic       cen;  // one-in-two clock enable.
        logic [1:0] h;    // pixel phase.
        logic       vb;   // vertical blank level.
    } video_t;

    // the board wires the DMA count to the table address in this order.
    // bit 10 is the done flag and never reaches the address bus.
    function automatic logic [tbl_addr_w-1:0] scramble_addr(input logic [tbl_addr_w:0] cnt);
        logic [tbl_addr_w-1:0] a;
        a    = '0;
        a[2] = cnt[0];
        a[6] = cnt[1];
        a[3] = cnt[2];
        a[4] = cnt[3];
        a[7] = cnt[4];
        a[8] = cnt[5];
        a[9] = cnt[6];
        a[5] = cnt[7];
        a[0] = cnt[8];  // lane select bits end up at the bottom.
        a[1] = cnt[9];
        return a;
    endfunction

endpackage

`default_nettype wire

// File: logic/sprite_dma_top.sv
`timescale 1ns/1ns
`default_nettype none

module sprite_dma_top import sprite_dma_pkg::*; #(
    parameter int LINE_TICKS   = 64,
    parameter int FRAME_LINES  = 32,
    parameter int VBLANK_LINES = 4
) (
    input  wire        clk,
    input  wire        rst_n,
    input  cpu_wr_t    cpu,
    output logic       cpu_hold,
    output logic       dma_done,
    output obj_entry_t entry
);

    video_t                vid;       // timing strobes shared by the DMA.
    logic                  busrq_n;
    logic                  busak_n;
    logic [tbl_addr_w-1:0] dma_addr;  // scrambled table address.
    logic [7:0]            dma_data;

    video_timing #(
        .LINE_TICKS   (LINE_TICKS),
        .FRAME_LINES  (FRAME_LINES),
        .VBLANK_LINES (VBLANK_LINES)
    ) u_timing (
        .clk   (clk),
        .rst_n (rst_n),
        .vid   (vid)
    );

    // the table RAM only needs the clock enable from the timing block.
    work_ram u_wram (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (vid.cen),
        .cpu      (cpu),
        .busrq_n  (busrq_n),
        .dma_addr (dma_addr),
        .busak_n  (busak_n),
        .dma_data (dma_data),
        .cpu_hold (cpu_hold)
    );

    obj_dma u_dma (
        .clk      (clk),
        .rst_n    (rst_n),
        .vid      (vid),
        .busak_n  (busak_n),
        .dma_data (dma_data),
        .busrq_n  (busrq_n),
        .dma_addr (dma_addr),
        .dma_done (dma_done),
        .entry    (entry)
    );

endmodule

`default_nettype wire

// File: logic/video_timing.sv
`timescale 1ns/1ns
`default_nettype none

module video_timing import sprite_dma_pkg::*; #(
    parameter int LINE_TICKS   = 64,   // cen ticks per line, a multiple of 4.
    parameter int FRAME_LINES  = 32,
    parameter int VBLANK_LINES = 4
) (
    input  wire    clk,
    input  wire    rst_n,
    output video_t vid
);

    localparam int TW = (LINE_TICKS > 4) ? $clog2(LINE_TICKS) : 2;
    localparam int LW = (FRAME_LINES > 2) ? $clog2(FRAME_LINES) : 1;

    localparam logic [TW-1:0] TICK_LAST   = TW'(LINE_TICKS - 1);
    localparam logic [LW-1:0] LINE_LAST   = LW'(FRAME_LINES - 1);
    localparam logic [LW-1:0] VBLANK_LINE = LW'(FRAME_LINES - VBLANK_LINES);

    logic          cen_r;  // toggles every clk, so it is high on every other edge.
    logic [TW-1:0] tick;   // cen ticks within the current line.
    logic [LW-1:0] line;   // line within the frame.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_r <= 1'b0;
        end else begin
            cen_r <= ~cen_r;
        end
    end

    // line and frame counters only move on cen ticks.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick <= '0;
            line <= '0;
        end else if (cen_r) begin
            if (tick == TICK_LAST) begin
                tick <= '0;  // the line wraps with h back at 0.
                line <= (line == LINE_LAST) ? '0 : line + 1'b1;
            end else begin
                tick <= tick + 1'b1;
            end
        end
    end

    // vb changes together with the line, so its rising edge always lands on h = 0.
    always_comb begin
        vid.cen = cen_r;
        vid.h   = tick[1:0];
        vid.vb  = (line >= VBLANK_LINE);  // last VBLANK_LINES lines of the frame.
    end

endmodule

`default_nettype wire

// File: logic/work_ram.sv
`timescale 1ns/1ns
`default_nettype none

module work_ram import sprite_dma_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   cen,
    input  cpu_wr_t               cpu,
    input  wire                   busrq_n,
    input  wire  [tbl_addr_w-1:0] dma_addr,
    output logic                  busak_n,
    output logic [7:0]            dma_data,
    output logic                  cpu_hold
);

    localparam int DEPTH = 1 << tbl_addr_w;

    logic [7:0] mem [0:DEPTH-1];  // sprite table as the CPU sees it.

    // the grant follows the request one cen tick later, in both directions.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busak_n <= 1'b1;
        end else if (cen) begin
            busak_n <= busrq_n;
        end
    end

    // CPU side of the table.
    // While the DMA owns the bus the CPU has no path to the RAM.
    always_ff @(posedge clk) begin
        if (cen && cpu.wr && busak_n) begin
            mem[cpu.addr] <= cpu.data;
        end
    end

    // the DMA read port answers one cen tick after the address.
    always_ff @(posedge clk) begin
        if (cen) begin
            dma_data <= mem[dma_addr];  // read every tick, the DMA picks its phase.
        end
    end

    // the CPU is halted from the request until the grant is returned.
    assign cpu_hold = ~busrq_n | ~busak_n;

endmodule

`default_nettype wire

// File: testbench/sprite_dma_sva.sv
`timescale 1ns/1ns
`default_nettype none

module sprite_dma_sva import sprite_dma_pkg::*; (
    input wire    clk,
    input wire    rst_n,
    input video_t vid,
    input wire    busrq_n,
    input wire    busak_n,
    input wire    dma_done,
    input wire    valid
);

    // the bus goes back only after bit 10 of the count has set.
    a_release_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busrq_n) |-> $past(dma_done))
        else $error("busrq_n rose while dma_done was low");

    a_grant_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busak_n) |-> $past(!busrq_n))
        else $error("busak_n fell without a bus request");

    // the object buffer is being written for as long as the DMA holds the bus.
    a_no_valid_in_copy: assert property (@(posedge clk) disable iff (!rst_n)
        !busak_n |-> !valid)
        else $error("entry valid was high during the table copy");

    // vb moves on a cen edge and the next cen edge comes two clocks later.
    a_request_after_vb: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(vid.vb) |-> ##2 $fell(busrq_n))
        else $error("busrq_n did not fall one cen tick after the vb edge");

endmodule

bind obj_dma sprite_dma_sva u_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .vid      (vid),
    .busrq_n  (busrq_n),
    .busak_n  (busak_n),
    .dma_done (dma_done),
    .valid    (entry.valid)
);

`default_nettype wire

// File: testbench/tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_checker import sprite_dma_pkg::*; (
    input  wire                clk,
    input  wire                rst_n,
    input  obj_entry_t         entry,
    input  wire                dma_done,
    input  logic [1023:0][7:0] shadow,     // table contents as the CPU wrote them.
    output int                 errors,
    output int                 checks,     // entries compared.
    output int                 wraps,      // index steps from 255 back to 0.
    output int                 hi_checks   // lane 3 entries whose table byte had bits 7:5 set.
);

    logic [1023:0][7:0] tbl;         // the table as it stood when the last copy finished.
    logic               done_l;
    logic               prev_valid;
    logic [7:0]         prev_idx;
    obj_attr_t          exp_attr;

    // lane k holds the byte at the scrambled address of k * 256 + idx.
    function automatic obj_attr_t expected_attr(input logic [7:0] idx,
                                                input logic [1023:0][7:0] t);
        obj_attr_t a;
        a.attr0 = t[scramble_addr({3'd0, idx})];
        a.attr1 = t[scramble_addr({3'd1, idx})];
        a.attr2 = t[scramble_addr({3'd2, idx})];
        a.attr3 = t[scramble_addr({3'd3, idx})][4:0];  // only five bits survive.
        return a;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_l     <= 1'b0;
            prev_valid <= 1'b0;
            prev_idx   <= '0;
        end else begin
            done_l     <= dma_done;
            prev_valid <= entry.valid;
            prev_idx   <= entry.idx;
            if (dma_done && !done_l) begin
                tbl <= shadow;  // the CPU is held off for the whole copy.
            end
            // an entry is new when valid rises or the index moves on.
            if (entry.valid && (!prev_valid || entry.idx != prev_idx)) begin
                exp_attr = expected_attr(entry.idx, tbl);
                checks++;
                if (entry.attr !== exp_attr) begin
                    errors++;
                    $display("FAIL entry.attr idx 0x%02h: expected 0x%08h actual 0x%08h",
                             entry.idx, exp_attr, entry.attr);
                end
                if (prev_valid && entry.idx != prev_idx + 8'd1) begin
                    errors++;
                    $display("FAIL entry.idx: expected 0x%02h actual 0x%02h",
                             prev_idx + 8'd1, entry.idx);
                end
                if (prev_valid && entry.idx == 8'd0) begin
                    wraps++;
                end
                if (tbl[scramble_addr({3'd3, entry.idx})][7:5] != 3'd0) begin
                    hi_checks++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;  // free-running, the run ends by $finish.
    end

    // reset lets go 1 ns after an edge, so no flop sees it change on the edge.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/tb_sprite_dma.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sprite_dma import sprite_dma_pkg::*; ();

    localparam int LINE_TICKS     = 64;
    localparam int FRAME_LINES    = 80;   // a frame must hold the 4096-tick copy and more.
    localparam int VBLANK_LINES   = 8;
    localparam int NUM_FRAMES     = 3;
    localparam int REWRITES       = 64;   // table bytes changed between frames.
    localparam int FRAME_CLKS     = 2 * LINE_TICKS * FRAME_LINES;  // cen is every other clock.
    localparam int TIMEOUT_CYCLES = FRAME_CLKS * (NUM_FRAMES + 1) + 4000;
    localparam logic [31:0] LFSR_SEED = 32'h157a_fa12;

    logic               clk;
    logic               rst_n;
    cpu_wr_t            cpu;
    logic               cpu_hold;
    logic               dma_done;
    obj_entry_t         entry;
    logic [1023:0][7:0] shadow;       // what the CPU believes is in the table.
    logic [31:0]        lfsr_state;
    logic               hold_l;
    logic               done_l;
    int                 seq_errors;   // counted by the stimulus process only.
    int                 hold_errors;  // counted by the bus monitor only.
    int                 chk_errors;
    int                 checks;
    int                 wraps;
    int                 hi_checks;
    int                 cycles;
    int                 done_rises;
    int                 hold_rises;

    tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(8)) u_clock (.clk(clk), .rst_n(rst_n));

    sprite_dma_top #(
        .LINE_TICKS   (LINE_TICKS),
        .FRAME_LINES  (FRAME_LINES),
        .VBLANK_LINES (VBLANK_LINES)
    ) dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu      (cpu),
        .cpu_hold (cpu_hold),
        .dma_done (dma_done),
        .entry    (entry)
    );

    tb_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .entry     (entry),
        .dma_done  (dma_done),
        .shadow    (shadow),
        .errors    (chk_errors),
        .checks    (checks),
        .wraps     (wraps),
        .hi_checks (hi_checks)
    );

    // x^32 + x^22 + x^2 + x + 1, the new bit enters at the bottom.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};  // one step per bit taken.
        end
    endtask

    // wr is held over two edges so exactly one of them is a cen edge.
    task automatic cpu_write(input logic [9:0] addr, input logic [7:0] data);
        @(posedge clk);
        #1;
        while (cpu_hold) begin
            @(posedge clk);
            #1;
        end
        cpu.wr        = 1'b1;
        cpu.addr      = addr;
        cpu.data      = data;
        shadow[addr]  = data;
        repeat (2) @(posedge clk);
        #1;
        cpu.wr = 1'b0;
    endtask

    task automatic expect_low(input string name, input logic level);
        if (level !== 1'b0) begin
            seq_errors++;
            $display("FAIL %s: expected 0x0 actual 0x%0h", name, level);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [7:0]  data;
        logic [9:0]  addr;
        int          target;
        cpu        = '0;
        shadow     = '0;
        lfsr_state = LFSR_SEED;
        wait (rst_n);
        @(posedge clk);
        #1;
        expect_low("cpu_hold", cpu_hold);
        expect_low("dma_done", dma_done);
        expect_low("entry.valid", entry.valid);
        for (int i = 0; i < 1024; i++) begin
            next_bits(8, r);
            data = r[7:0];
            if (i[1:0] == 2'b11 && !i[2]) begin
                data[7:5] = 3'b111;  // lane 3 bytes with bits the buffer must drop.
            end
            cpu_write(i[9:0], data);
        end
        // the fill is well inside the first frame, vb has not come yet.
        expect_low("cpu_hold", cpu_hold);
        expect_low("dma_done", dma_done);
        expect_low("entry.valid", entry.valid);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            wait (!dma_done);
            wait (dma_done);
            wait (!cpu_hold);
            if (f < NUM_FRAMES - 1) begin
                for (int w = 0; w < REWRITES; w++) begin
                    next_bits(10, r);
                    addr = r[9:0];
                    next_bits(8, r);
                    data = (r[7:0] == shadow[addr]) ? ~r[7:0] : r[7:0];  // always a new value.
                    cpu_write(addr, data);
                end
            end
        end
        target = wraps + 2;
        wait (wraps >= target);  // two more full passes in display.
        if (done_rises != NUM_FRAMES || hold_rises != NUM_FRAMES) begin
            seq_errors++;
            $display("expected %0d copies but saw %0d dma_done and %0d cpu_hold rises",
                     NUM_FRAMES, done_rises, hold_rises);
        end
        if (checks < 256 * NUM_FRAMES || wraps < NUM_FRAMES) begin
            seq_errors++;
            $display("too few entries were compared for a full pass in each frame");
        end
        if (hi_checks == 0) begin
            seq_errors++;
            $display("no lane 3 entry came from a table byte with its top bits set");
        end
        $display("errors: %0d sequence, %0d bus, %0d entry; %0d entries checked, %0d wraps",
                 seq_errors, hold_errors, chk_errors, checks, wraps);
        if (seq_errors + hold_errors + chk_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // cpu_hold opens a fresh copy and only drops once that copy is done.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_l <= 1'b0;
            done_l <= 1'b0;
        end else begin
            hold_l <= cpu_hold;
            done_l <= dma_done;
            if (cpu_hold && !hold_l) begin
                hold_rises++;
                if (dma_done || done_rises != hold_rises - 1) begin
                    hold_errors++;
                    $display("cpu_hold rose while dma_done was high or a copy was missed");
                end
            end
            if (dma_done && !done_l) begin
                done_rises++;
                if (!cpu_hold) begin
                    hold_errors++;
                    $display("dma_done rose while the CPU was not held");
                end
            end
            if (!cpu_hold && hold_l && !dma_done) begin
                hold_errors++;
                $display("cpu_hold fell before the copy was done");
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: the test did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
logic/sprite_dma_pkg.sv
logic/video_timing.sv
logic/work_ram.sv
logic/obj_ram.sv
logic/obj_dma.sv
logic/sprite_dma_top.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/sprite_dma_sva.sv
testbench/tb_sprite_dma.sv
